// ==== hw/mm_macros.svh ====
// widths, map bases, control register bit positions and timer counts
// for the memory-mapped glue block
`ifndef MM_MACROS_SVH
`define MM_MACROS_SVH

// bus widths
`define MM_ADDR_W          8      // word address
`define MM_DATA_W          16     // data bus
`define MM_INDEX_W         6      // word index within a region

// memory map
`define MM_RAM_WORDS       64     // chip ram at 0x00..0x3f
`define MM_RTC_BASE        'h40   // rtc nibble window
`define MM_RTC_WORDS       16     // one word per nibble
`define MM_RTC_W           64     // rtc value width
`define MM_NIBBLE_W        4
`define MM_CTRL_ADDR       'h50   // control register

// control register layout
`define MM_CTRL_W          5      // stored bits, usr_rst not kept
`define MM_CTRL_LED        0      // power led enable
`define MM_CTRL_MEMCFG_LO  1
`define MM_CTRL_MEMCFG_HI  4
`define MM_MEMCFG_W        4
`define MM_CTRL_USR_RST    5      // write-only, reads 0

// system timer
`define MM_RESET_FRAMES    4      // sof pulses held in reset
`define MM_FRAME_CNT_W     3
`define MM_LED_CNT_W       6

`endif

// ==== hw/mm_pkg.sv ====
// shared enums of the glue block: bus states, access regions and
// reset states

package mm_pkg;

	// ------------------------------------------------------------------------
	// four-phase bus FSM
	// ------------------------------------------------------------------------
	typedef enum logic [1:0] {
		bs_idle    = 2'd0,  // waiting for req
		bs_access  = 2'd1,  // acc_en strobe
		bs_ack     = 2'd2,  // ack held until req drops
		bs_release = 2'd3   // ack low, back to idle
	} bus_state_t;

	// region opcode from the address decoder
	typedef enum logic [1:0] {
		rg_chip = 2'd0,  // 64-word chip ram
		rg_rtc  = 2'd1,  // rtc nibble window, read only
		rg_ctrl = 2'd2,  // control register
		rg_none = 2'd3   // unmapped, reads 0
	} region_t;

	// system reset hold
	typedef enum logic {
		rs_hold = 1'b0,  // counting sof pulses
		rs_run  = 1'b1
	} rst_state_t;

endpackage

// ==== hw/mm_bus_ctrl.sv ====
// four-phase req/ack bus FSM, issues the one-cycle access strobe
`timescale 1ns/1ns

module mm_bus_ctrl (
	input  logic clk,
	input  logic arst_n,
	input  logic req,      // host request
	input  logic sys_rst,  // held reset, blocks new accesses
	output logic ack,      // host acknowledge
	output logic acc_en    // one-cycle access strobe to the regs
);
	import mm_pkg::*;

	bus_state_t state;
	bus_state_t state_nxt;

	// ------------------------------------------------------------------------
	// next state
	// ------------------------------------------------------------------------
	always_comb begin
		state_nxt = state;
		case (state)
			bs_idle: begin
				// no new cycle while the system is in reset
				if (req && !sys_rst)
					state_nxt = bs_access;
			end
			bs_access: begin
				state_nxt = bs_ack;  // data registered on this edge
			end
			bs_ack: begin
				if (!req)
					state_nxt = bs_release;  // host is done
			end
			bs_release: begin
				state_nxt = bs_idle;
			end
			default: begin
				state_nxt = bs_idle;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// state and ack registers
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= bs_idle;
			ack   <= 1'b0;
		end else begin
			state <= state_nxt;
			// ack follows req while in bs_ack
			// rises two edges after req was taken, falls on the edge req is seen low
			ack   <= (state == bs_ack) && req;
		end
	end

	// strobe in the cycle after req was accepted
	assign acc_en = (state == bs_access);

endmodule

// ==== hw/mm_sys_timer.sv ====
// system reset hold counted in sof pulses, and the free-running
// power led dimming counter
`timescale 1ns/1ns

module mm_sys_timer (
	input  logic clk,
	input  logic arst_n,
	input  logic sof,      // start-of-frame pulse
	input  logic usr_rst,  // user reset from the control register
	output logic sys_rst,  // held system reset
	output logic led_dim   // dimming gate for the power led
);
	`include "mm_macros.svh"
	import mm_pkg::*;

	rst_state_t                 rst_state;
	logic [`MM_FRAME_CNT_W-1:0] frame_cnt;  // sof pulses seen in rs_hold
	logic [`MM_LED_CNT_W-1:0]   led_cnt;

	// ------------------------------------------------------------------------
	// reset hold
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rst_state <= rs_hold;
			frame_cnt <= '0;
		end else if (usr_rst) begin
			// restart the hold from zero, also from rs_run
			rst_state <= rs_hold;
			frame_cnt <= '0;
		end else if ((rst_state == rs_hold) && sof) begin
			if (frame_cnt == `MM_FRAME_CNT_W'(`MM_RESET_FRAMES - 1)) begin
				rst_state <= rs_run;  // last frame counted
				frame_cnt <= '0;
			end else begin
				frame_cnt <= frame_cnt + 1'b1;
			end
		end
	end

	assign sys_rst = (rst_state == rs_hold);  // drops one cycle after the last sof

	// ------------------------------------------------------------------------
	// led dimming
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			led_cnt <= '0;
		else
			led_cnt <= led_cnt + 1'b1;  // free running, wraps every 64
	end

	// low for 4 of every 64 cycles
	assign led_dim = |led_cnt[`MM_LED_CNT_W-1:2];

endmodule

// ==== hw/mm_addr_decode.sv ====
// address decoder, word address to region opcode and word index
`timescale 1ns/1ns
`include "mm_macros.svh"

module mm_addr_decode (
	input  logic [`MM_ADDR_W-1:0]  addr,
	output mm_pkg::region_t        region,
	output logic [`MM_INDEX_W-1:0] index
);
	import mm_pkg::*;

	// region bounds at address width
	localparam logic [`MM_ADDR_W-1:0] ram_top  = `MM_ADDR_W'(`MM_RAM_WORDS);
	localparam logic [`MM_ADDR_W-1:0] rtc_base = `MM_ADDR_W'(`MM_RTC_BASE);
	localparam logic [`MM_ADDR_W-1:0] rtc_top  = `MM_ADDR_W'(`MM_RTC_BASE + `MM_RTC_WORDS);
	localparam logic [`MM_ADDR_W-1:0] ctrl_adr = `MM_ADDR_W'(`MM_CTRL_ADDR);

	logic [`MM_ADDR_W-1:0] rtc_off;  // offset into the rtc window

	assign rtc_off = addr - rtc_base;

	always_comb begin
		region = rg_none;  // unmapped by default
		index  = '0;
		if (addr < ram_top) begin
			region = rg_chip;
			index  = addr[`MM_INDEX_W-1:0];
		end else if ((addr >= rtc_base) && (addr < rtc_top)) begin
			region = rg_rtc;
			index  = rtc_off[`MM_INDEX_W-1:0];  // nibble number
		end else if (addr == ctrl_adr) begin
			region = rg_ctrl;  // single register with index 0
		end
	end

endmodule

// ==== hw/mm_regs.sv ====
// chip ram, control register, rtc nibble read and the OR-combined
// read data register
`timescale 1ns/1ns
`include "mm_macros.svh"

module mm_regs (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    sys_rst,  // clears the read register
	input  logic                    acc_en,   // one-cycle access strobe
	input  logic                    we,
	input  mm_pkg::region_t         region,
	input  logic [`MM_INDEX_W-1:0]  index,
	input  logic [`MM_DATA_W-1:0]   wdata,
	input  logic [`MM_RTC_W-1:0]    rtc,
	input  logic                    led_dim,
	output logic [`MM_DATA_W-1:0]   rdata,
	output logic                    usr_rst,
	output logic                    pwr_led,  // active low
	output logic [`MM_MEMCFG_W-1:0] memcfg
);
	import mm_pkg::*;

	logic [`MM_DATA_W-1:0] chip_ram [`MM_RAM_WORDS];
	logic [`MM_CTRL_W-1:0] ctrl_q;  // led + memcfg
	logic                  wr_en;
	logic                  rd_en;
	logic [`MM_DATA_W-1:0] chip_rd;
	logic [`MM_DATA_W-1:0] rtc_rd;
	logic [`MM_DATA_W-1:0] ctrl_rd;
	logic [`MM_DATA_W-1:0] rd_bus;

	assign wr_en = acc_en && we;
	assign rd_en = acc_en && !we;

	// ------------------------------------------------------------------------
	// writes
	// ------------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (wr_en && (region == rg_chip))
			chip_ram[index] <= wdata;  // index covers all 64 words
	end

	// survives a user reset as only arst_n clears it
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			ctrl_q <= '0;
		else if (wr_en && (region == rg_ctrl))
			ctrl_q <= wdata[`MM_CTRL_W-1:0];  // bits 4:0 also on a usr_rst write
	end

	// one-cycle pulse straight off the strobe
	assign usr_rst = wr_en && (region == rg_ctrl) && wdata[`MM_CTRL_USR_RST];

	// ------------------------------------------------------------------------
	// read terms that stay zero unless their region is selected
	// ------------------------------------------------------------------------
	assign chip_rd = (region == rg_chip) ? chip_ram[index] : '0;

	// nibble n is rtc[4n+3:4n] zero extended
	assign rtc_rd  = (region == rg_rtc) ?
		`MM_DATA_W'(rtc[{index[3:0], 2'b00} +: `MM_NIBBLE_W]) : '0;

	assign ctrl_rd = (region == rg_ctrl) ? `MM_DATA_W'(ctrl_q) : '0;  // bit 5 reads 0

	assign rd_bus  = chip_rd | rtc_rd | ctrl_rd;  // rg_none gives 0

	// read data register stable while ack is held
	always_ff @(posedge clk) begin
		if (sys_rst)
			rdata <= '0;
		else if (rd_en)
			rdata <= rd_bus;
	end

	// ------------------------------------------------------------------------
	// control outputs
	// ------------------------------------------------------------------------
	assign memcfg  = ctrl_q[`MM_CTRL_MEMCFG_HI:`MM_CTRL_MEMCFG_LO];
	assign pwr_led = ~(ctrl_q[`MM_CTRL_LED] & led_dim);  // off after reset

endmodule

// ==== hw/mm_top.sv ====
// glue block top level with bus FSM, system timer, address
// decoder and register block
`timescale 1ns/1ns
`include "mm_macros.svh"

module mm_top (
	input  logic                    clk,
	input  logic                    arst_n,
	// host bus
	input  logic                    req,
	input  logic                    we,
	input  logic [`MM_ADDR_W-1:0]   addr,
	input  logic [`MM_DATA_W-1:0]   wdata,
	output logic                    ack,
	output logic [`MM_DATA_W-1:0]   rdata,
	// system
	input  logic [`MM_RTC_W-1:0]    rtc,
	input  logic                    sof,  // start of frame
	output logic                    rst_out,
	output logic                    pwr_led,
	output logic [`MM_MEMCFG_W-1:0] memcfg
);
	import mm_pkg::*;

	logic                   acc_en;   // access strobe from bus FSM to regs
	logic                   sys_rst;  // held reset from the timer
	logic                   usr_rst;  // control register write of bit 5
	logic                   led_dim;
	region_t                region;
	logic [`MM_INDEX_W-1:0] index;

	// ------------------------------------------------------------------------
	// bus FSM
	// ------------------------------------------------------------------------
	mm_bus_ctrl u_bus_ctrl (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (req),
		.sys_rst (sys_rst),
		.ack     (ack),
		.acc_en  (acc_en)
	);

	// reset hold and led dimming
	mm_sys_timer u_sys_timer (
		.clk     (clk),
		.arst_n  (arst_n),
		.sof     (sof),
		.usr_rst (usr_rst),
		.sys_rst (sys_rst),
		.led_dim (led_dim)
	);

	mm_addr_decode u_addr_decode (
		.addr   (addr),
		.region (region),
		.index  (index)
	);

	// ------------------------------------------------------------------------
	// memory and registers
	// ------------------------------------------------------------------------
	mm_regs u_regs (
		.clk     (clk),
		.arst_n  (arst_n),
		.sys_rst (sys_rst),
		.acc_en  (acc_en),
		.we      (we),
		.region  (region),
		.index   (index),
		.wdata   (wdata),
		.rtc     (rtc),
		.led_dim (led_dim),
		.rdata   (rdata),
		.usr_rst (usr_rst),
		.pwr_led (pwr_led),
		.memcfg  (memcfg)
	);

	assign rst_out = sys_rst;  // reset status to the outside

endmodule

// ==== verif/tb_clock.sv ====
// free-running testbench clock
`timescale 1ns/1ns

module tb_clock #(
	parameter int period = 40  // ns
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;  // 50% duty
	end

endmodule

// ==== verif/mm_props.sv ====
// handshake and held-reset assertions on the bus FSM
`timescale 1ns/1ns

module mm_props (
	input logic               clk,
	input logic               arst_n,
	input logic               req,
	input logic               sys_rst,
	input logic               ack,
	input mm_pkg::bus_state_t state
);
	import mm_pkg::*;

	int unsigned err_cnt = 0;  // failed assertions so far

	// ack only rises on a sampled req
	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		!req |=> !ack)
	else begin
		$error("ack rose while req was low");
		err_cnt++;
	end

	// back-pressure, ack held as long as req
	ack_held: assert property (@(posedge clk) disable iff (!arst_n)
		ack && req |=> ack)
	else begin
		$error("ack dropped while req was still high");
		err_cnt++;
	end

	// no new cycle out of idle while held in reset
	rst_blocks_bus: assert property (@(posedge clk) disable iff (!arst_n)
		sys_rst && (state == bs_idle) |=> (state == bs_idle) && !ack)
	else begin
		$error("bus cycle started while sys_rst was high");
		err_cnt++;
	end

endmodule

// ==== verif/tb_top.sv ====
// testbench top with stimulus table, four-phase host access task, reset hold,
// led dimming and control register checks
`timescale 1ns/1ns

module tb_top;

	localparam int op_wr   = 0;  // write with rst_out at ack as exp
	localparam int op_rd   = 1;  // read with rdata as exp
	localparam int op_rst  = 2;  // rst_out now
	localparam int op_held = 3;  // wait for run with sof pulses held as exp
	localparam int op_cfg  = 4;  // memcfg now
	localparam int op_led  = 5;  // pwr_led low count over 64 cycles
	localparam int wait_limit = 400;  // cycles per wait

	logic        clk;
	logic        arst_n;
	logic        req;
	logic        we;
	logic [7:0]  addr;
	logic [15:0] wdata;
	logic        ack;
	logic [15:0] rdata;
	logic [63:0] rtc;
	logic        sof;
	logic        rst_out;
	logic        pwr_led;
	logic [3:0]  memcfg;

	int          sof_div = 0;
	int          sof_seen = 0;     // sof pulses out of reset
	int          hold_mark = 0;    // sof_seen when rst_out rose
	int          held_frames = 0;  // sof pulses of the last hold
	logic        rst_prev = 1'b1;

	// stimulus table
	int          op_q[$];
	logic [7:0]  addr_q[$];
	logic [15:0] wdata_q[$];
	logic [31:0] exp_q[$];
	string       name_q[$];

	tb_clock #(.period(40)) u_clock (.clk(clk));

	mm_top uut (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (req),
		.we      (we),
		.addr    (addr),
		.wdata   (wdata),
		.ack     (ack),
		.rdata   (rdata),
		.rtc     (rtc),
		.sof     (sof),
		.rst_out (rst_out),
		.pwr_led (pwr_led),
		.memcfg  (memcfg)
	);

	bind mm_bus_ctrl mm_props u_props (
		.clk     (clk),
		.arst_n  (arst_n),
		.req     (req),
		.sys_rst (sys_rst),
		.ack     (ack),
		.state   (state)
	);

	// ------------------------------------------------------------------------
	// sof every 20 cycles and a count of frames held in reset
	// ------------------------------------------------------------------------
	always @(negedge clk) begin
		sof     = (sof_div == 19);
		sof_div = (sof_div == 19) ? 0 : sof_div + 1;
	end

	always @(posedge clk)
		if (arst_n && sof)
			sof_seen++;

	always @(negedge clk) begin
		if (!arst_n || (rst_out && !rst_prev))
			hold_mark = sof_seen;  // hold starts
		if (!rst_out && rst_prev)
			held_frames = sof_seen - hold_mark;
		rst_prev = rst_out;
	end

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Some tests failed");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (act !== exp)
			fail_run($sformatf("** Error: %s expected %0h actual %0h", name, exp, act));
	endtask

	task automatic add_step(input int op, input logic [7:0] a, input logic [15:0] d,
		input logic [31:0] e, input string name);
		op_q.push_back(op);
		addr_q.push_back(a);
		wdata_q.push_back(d);
		exp_q.push_back(e);
		name_q.push_back(name);
	endtask

	// one four-phase cycle with req held two cycles past ack
	task automatic bus_access(input string name, input logic wr, input logic [7:0] a,
		input logic [15:0] d, output logic [15:0] rd, output logic rst_at_ack);
		int   n;
		logic rst_at_req;
		@(negedge clk);
		req        = 1'b1;
		we         = wr;
		addr       = a;
		wdata      = d;
		rst_at_req = rst_out;
		n          = 0;
		while (ack !== 1'b1) begin
			if (n == wait_limit)
				fail_run({"timed out waiting for ack to rise in ", name});
			@(negedge clk);
			n++;
		end
		rd         = rdata;
		rst_at_ack = rst_out;
		// req sampled half a cycle after the drive, ack two edges later
		if (!rst_at_req)
			check_value({name, " ack latency"}, 3, n);
		repeat (2) begin
			@(negedge clk);
			check_value({name, " ack held"}, 1, ack);
			if (!wr)
				check_value({name, " rdata held"}, rd, rdata);
		end
		req = 1'b0;
		n   = 0;
		while (ack !== 1'b0) begin
			if (n == wait_limit)
				fail_run({"timed out waiting for ack to fall in ", name});
			@(negedge clk);
			n++;
		end
		check_value({name, " ack release"}, 1, n);  // one edge after req drops
	endtask

	task automatic wait_run(input string name);
		int n;
		n = 0;
		while (rst_out !== 1'b0) begin
			if (n == wait_limit)
				fail_run({"timed out waiting for rst_out to fall in ", name});
			@(negedge clk);
			n++;
		end
		@(negedge clk);  // frame monitor has seen the fall
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		int          lows;
		logic [15:0] rd;
		logic        rst_ack;
		void'($urandom(32'h72e68a9b));
		rtc    = {$urandom, $urandom};
		arst_n = 1'b0;
		req    = 1'b0;
		we     = 1'b0;
		addr   = '0;
		wdata  = '0;
		sof    = 1'b0;

		// power-on hold with a write that waits for it
		add_step(op_rst,  8'h00, 16'h0000, 1, "rst_out after reset");
		add_step(op_cfg,  8'h00, 16'h0000, 0, "memcfg after reset");
		add_step(op_wr,   8'h10, 16'h5a5a, 0, "write during hold");
		add_step(op_held, 8'h00, 16'h0000, 4, "frames held at power-on");
		add_step(op_led,  8'h00, 16'h0000, 0, "led off after reset");
		// chip ram
		add_step(op_wr, 8'h00, 16'h1234, 0, "ram write 00");
		add_step(op_wr, 8'h3f, 16'hbeef, 0, "ram write 3f");
		add_step(op_wr, 8'h21, 16'h0f0f, 0, "ram write 21");
		add_step(op_rd, 8'h00, 16'h0000, 16'h1234, "ram read 00");
		add_step(op_rd, 8'h3f, 16'h0000, 16'hbeef, "ram read 3f");
		add_step(op_rd, 8'h10, 16'h0000, 16'h5a5a, "ram read 10");
		add_step(op_wr, 8'h21, 16'hc3a5, 0, "ram rewrite 21");
		add_step(op_rd, 8'h21, 16'h0000, 16'hc3a5, "ram read 21");
		// zero-extended rtc nibbles
		for (int n = 0; n < 16; n += 5)
			add_step(op_rd, 8'h40 + n, 16'h0000, {28'h0, rtc[4 * n +: 4]},
				$sformatf("rtc read %0h", 8'h40 + n));
		add_step(op_wr, 8'h45, 16'hffff, 0, "rtc write 45");
		add_step(op_rd, 8'h45, 16'h0000, {28'h0, rtc[23:20]}, "rtc read 45 after write");
		// unmapped space
		add_step(op_wr, 8'h51, 16'hffff, 0, "unmapped write 51");
		add_step(op_rd, 8'h51, 16'h0000, 0, "unmapped read 51");
		add_step(op_rd, 8'h80, 16'h0000, 0, "unmapped read 80");
		add_step(op_rd, 8'hff, 16'h0000, 0, "unmapped read ff");
		// control register keeps only bits 4:0
		add_step(op_wr,  8'h50, 16'hffc7, 0, "ctrl write c7");
		add_step(op_cfg, 8'h00, 16'h0000, 4'h3, "memcfg 3");
		add_step(op_rd,  8'h50, 16'h0000, 16'h0007, "ctrl read 07");
		add_step(op_led, 8'h00, 16'h0000, 60, "led on dimmed");
		add_step(op_wr,  8'h50, 16'h0016, 0, "ctrl write 16");
		add_step(op_cfg, 8'h00, 16'h0000, 4'hb, "memcfg b");
		add_step(op_rd,  8'h50, 16'h0000, 16'h0016, "ctrl read 16");
		add_step(op_led, 8'h00, 16'h0000, 0, "led off");
		// user reset write completes its ack with rst_out already high
		add_step(op_wr,   8'h50, 16'h0036, 1, "user reset write");
		add_step(op_rst,  8'h00, 16'h0000, 1, "rst_out after user reset");
		add_step(op_held, 8'h00, 16'h0000, 4, "frames held after user reset");
		add_step(op_cfg,  8'h00, 16'h0000, 4'hb, "memcfg kept");
		add_step(op_rd,   8'h50, 16'h0000, 16'h0016, "ctrl kept");
		add_step(op_rd,   8'h00, 16'h0000, 16'h1234, "ram 00 kept");
		add_step(op_rd,   8'h3f, 16'h0000, 16'hbeef, "ram 3f kept");
		add_step(op_rd,   8'h21, 16'h0000, 16'hc3a5, "ram 21 kept");

		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		for (int i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				op_wr: begin
					bus_access(name_q[i], 1'b1, addr_q[i], wdata_q[i], rd, rst_ack);
					check_value(name_q[i], exp_q[i], rst_ack);
				end
				op_rd: begin
					bus_access(name_q[i], 1'b0, addr_q[i], wdata_q[i], rd, rst_ack);
					check_value(name_q[i], exp_q[i], rd);
				end
				op_rst:
					check_value(name_q[i], exp_q[i], rst_out);
				op_held: begin
					wait_run(name_q[i]);
					check_value(name_q[i], exp_q[i], held_frames);
				end
				op_cfg:
					check_value(name_q[i], exp_q[i], memcfg);
				default: begin
					lows = 0;
					repeat (64) begin
						@(negedge clk);
						if (pwr_led === 1'b0)
							lows++;  // led lit
					end
					check_value(name_q[i], exp_q[i], lows);
				end
			endcase
			check_value({name_q[i], " assertions"}, 0, uut.u_bus_ctrl.u_props.err_cnt);
		end

		if (uut.u_bus_ctrl.u_props.err_cnt == 0) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "assertion failures");
		end
	end

endmodule

// ==== tb.f ====
+incdir+hw
hw/mm_pkg.sv
hw/mm_bus_ctrl.sv
hw/mm_sys_timer.sv
hw/mm_addr_decode.sv
hw/mm_regs.sv
hw/mm_top.sv
verif/tb_clock.sv
verif/mm_props.sv
verif/tb_top.sv
